//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram_ctrl
FILELIST  = build.f
LOG       = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG); cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- build.f
rtl/sdram_pkg.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_row_tracker.sv
rtl/sdram_sequencer.sv
rtl/sdram_cmd_issue.sv
rtl/sdram_read_return.sv
rtl/sdram_ctrl_top.sv
testbench/sdram_device_model.sv
testbench/tb_sdram_ctrl.sv

//--- rtl/sdram_cmd_issue.sv
// Registered SDRAM pin drivers for command, address, bank, mask and write data
`timescale 1ns/1ps

module sdram_cmd_issue #(
    parameter int COL_W = 8,
    parameter int ROW_W = 12
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  sdram_pkg::state_t                 state_i,
    input  logic                              close_all_i,
    input  sdram_pkg::init_step_t             init_step_i,
    input  logic [sdram_pkg::DQM_W-1:0]       wr_i,
    input  logic [sdram_pkg::DATA_W-1:0]      wdata_i,
    input  logic [sdram_pkg::BANK_W-1:0]      bank_i,
    input  logic [ROW_W-1:0]                  row_i,
    input  logic [COL_W-1:0]                  col_i,
    output logic                              cke_o,
    output logic                              cs_o,
    output logic                              ras_o,
    output logic                              cas_o,
    output logic                              we_o,
    output logic [sdram_pkg::BANK_W-1:0]      ba_o,
    output logic [sdram_pkg::ADDR_PIN_W-1:0]  addr_o,
    output logic [sdram_pkg::DQM_W-1:0]       dqm_o,
    output logic [sdram_pkg::DATA_W-1:0]      dq_o,
    output logic                              dq_oe_o
);
    import sdram_pkg::*;

    cmd_t                  cmd_q;
    logic [ADDR_PIN_W-1:0] addr_q;
    logic [BANK_W-1:0]     ba_q;
    logic [DQM_W-1:0]      dqm_q;
    logic [DATA_W-1:0]     data_q;
    logic                  cke_q;
    logic                  oe_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cmd_q  <= CMD_NOP;
            addr_q <= '0;
            ba_q   <= '0;
            dqm_q  <= '0;
            cke_q  <= 1'b0;
            oe_q   <= 1'b0;
        end
        else
        begin
            // NOP unless the state below says otherwise
            cmd_q  <= CMD_NOP;
            addr_q <= '0;
            ba_q   <= '0;
            oe_q   <= 1'b0;
            case (state_i)
                // --------------------
                // Power-up steps
                // --------------------
                ST_INIT:
                    case (init_step_i)
                        STEP_CKE:       cke_q <= 1'b1;
                        STEP_PRECHARGE:
                        begin
                            cmd_q                 <= CMD_PRECHARGE;
                            addr_q[ALL_BANKS_BIT] <= 1'b1;
                        end
                        STEP_REFRESH:   cmd_q <= CMD_REFRESH;
                        STEP_LOAD_MODE:
                        begin
                            cmd_q  <= CMD_LOAD_MODE;
                            addr_q <= MODE_REG;
                        end
                        default:        cmd_q <= CMD_NOP;
                    endcase
                // Open the row in the request bank
                ST_ACTIVATE:
                begin
                    cmd_q  <= CMD_ACTIVE;
                    addr_q <= ADDR_PIN_W'(row_i);
                    ba_q   <= bank_i;
                end
                // Column access, no auto precharge
                ST_READ:
                begin
                    cmd_q                 <= CMD_READ;
                    addr_q                <= ADDR_PIN_W'(col_i);
                    addr_q[ALL_BANKS_BIT] <= 1'b0;
                    ba_q                  <= bank_i;
                    dqm_q                 <= '0;
                end
                ST_WRITE0:
                begin
                    cmd_q                 <= CMD_WRITE;
                    addr_q                <= ADDR_PIN_W'(col_i);
                    addr_q[ALL_BANKS_BIT] <= 1'b0;
                    ba_q                  <= bank_i;
                    // Mask is active high, enables are not
                    dqm_q                 <= ~wr_i;
                    oe_q                  <= 1'b1;
                end
                // One bank on a row swap, all banks ahead of refresh
                ST_PRECHARGE:
                begin
                    cmd_q                 <= CMD_PRECHARGE;
                    addr_q[ALL_BANKS_BIT] <= close_all_i;
                    ba_q                  <= bank_i;
                end
                ST_REFRESH:   cmd_q <= CMD_REFRESH;
                default:      cmd_q <= CMD_NOP;
            endcase
        end
    end

    // Write word launched with the WRITE command
    always_ff @(posedge clk_i)
    begin
        if (state_i == ST_WRITE0)
            data_q <= wdata_i;
    end

    assign {cs_o, ras_o, cas_o, we_o} = cmd_q;
    assign cke_o   = cke_q;
    assign ba_o    = ba_q;
    assign addr_o  = addr_q;
    assign dqm_o   = dqm_q;
    assign dq_o    = data_q;
    assign dq_oe_o = oe_q;

    // A driven write word carries at least one byte lane
    a_oe_write: assert property (@(posedge clk_i) disable iff (rst_i)
        dq_oe_o |-> (dqm_o != '1));

endmodule

//--- rtl/sdram_ctrl_top.sv
// Single-word SDR SDRAM controller top level
`timescale 1ns/1ps

module sdram_ctrl_top #(
    parameter int ADDR_W         = 24,
    parameter int COL_W          = 8,
    parameter int START_CYCLES   = 200,
    parameter int REFRESH_CYCLES = 500,
    parameter int TRCD_CYCLES    = 1,
    parameter int TRP_CYCLES     = 1,
    parameter int TRFC_CYCLES    = 3,
    parameter int READ_LATENCY   = 2
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // Request side
    input  logic                              rd_i,
    input  logic [sdram_pkg::DQM_W-1:0]       wr_i,
    input  logic [31:0]                       addr_i,
    input  logic [sdram_pkg::DATA_W-1:0]      wdata_i,
    output logic                              accept_o,
    output logic                              ack_o,
    output logic [sdram_pkg::DATA_W-1:0]      rdata_o,
    // Device pins
    output logic                              cke_o,
    output logic                              cs_o,
    output logic                              ras_o,
    output logic                              cas_o,
    output logic                              we_o,
    output logic [sdram_pkg::BANK_W-1:0]      ba_o,
    output logic [sdram_pkg::ADDR_PIN_W-1:0]  addr_o,
    output logic [sdram_pkg::DQM_W-1:0]       dqm_o,
    output logic [sdram_pkg::DATA_W-1:0]      dq_o,
    output logic                              dq_oe_o,
    input  logic [sdram_pkg::DATA_W-1:0]      dq_i
);
    import sdram_pkg::*;

    // Byte address minus lane, column and bank bits
    localparam int ROW_W = ADDR_W - COL_W - BANK_W - 2;

    logic               refresh_pending, refresh_done, close_all;
    init_step_t         init_step;
    row_class_t         row_class;
    state_t             state;
    logic [BANK_W-1:0]  bank;
    logic [ROW_W-1:0]   row;
    logic [COL_W-1:0]   col;

    sdram_refresh_timer #(.START_CYCLES(START_CYCLES), .REFRESH_CYCLES(REFRESH_CYCLES)) u_timer (
        .clk_i, .rst_i, .refresh_done_i(refresh_done),
        .refresh_pending_o(refresh_pending), .init_step_o(init_step));

    sdram_row_tracker #(.COL_W(COL_W), .ROW_W(ROW_W)) u_rows (
        .clk_i, .rst_i, .addr_i, .state_i(state), .close_all_i(close_all),
        .row_class_o(row_class), .bank_o(bank), .row_o(row), .col_o(col));

    sdram_sequencer #(.TRCD_CYCLES(TRCD_CYCLES), .TRP_CYCLES(TRP_CYCLES),
        .TRFC_CYCLES(TRFC_CYCLES), .READ_LATENCY(READ_LATENCY)) u_seq (
        .clk_i, .rst_i, .rd_i, .wr_i, .refresh_pending_i(refresh_pending),
        .row_class_i(row_class), .state_o(state), .close_all_o(close_all),
        .refresh_done_o(refresh_done), .accept_o);

    sdram_cmd_issue #(.COL_W(COL_W), .ROW_W(ROW_W)) u_cmd (
        .clk_i, .rst_i, .state_i(state), .close_all_i(close_all), .init_step_i(init_step),
        .wr_i, .wdata_i, .bank_i(bank), .row_i(row), .col_i(col),
        .cke_o, .cs_o, .ras_o, .cas_o, .we_o, .ba_o, .addr_o, .dqm_o, .dq_o, .dq_oe_o);

    sdram_read_return #(.READ_LATENCY(READ_LATENCY)) u_ret (
        .clk_i, .rst_i, .state_i(state), .dq_i, .rdata_o, .ack_o);

endmodule

//--- rtl/sdram_pkg.sv
// SDRAM controller shared encodings, state types and device widths
package sdram_pkg;

    // --------------------
    // Device widths
    // --------------------
    localparam int DATA_W     = 32;
    localparam int DQM_W      = 4;
    localparam int BANK_W     = 2;
    localparam int ADDR_PIN_W = 13;
    localparam int DELAY_W    = 4;

    // All banks on PRECHARGE, auto precharge on READ / WRITE
    localparam int ALL_BANKS_BIT = 10;

    // Burst length 1, sequential, CAS latency 2
    localparam logic [ADDR_PIN_W-1:0] MODE_REG = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

    // Pin command as {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } cmd_t;

    // Sequencer states
    typedef enum logic [3:0] {
        ST_INIT, ST_DELAY, ST_IDLE, ST_ACTIVATE, ST_READ,
        ST_READ_WAIT, ST_WRITE0, ST_WRITE1, ST_PRECHARGE, ST_REFRESH
    } state_t;

    // Request against the open-row table
    typedef enum logic [1:0] {ROW_HIT, ROW_MISS, ROW_CLOSED} row_class_t;

    // Power-up sequence steps
    typedef enum logic [2:0] {
        STEP_NONE, STEP_CKE, STEP_PRECHARGE, STEP_REFRESH, STEP_LOAD_MODE
    } init_step_t;

endpackage

//--- rtl/sdram_read_return.sv
// Read data capture and ack pulse generation for reads and writes
`timescale 1ns/1ps

module sdram_read_return #(
    parameter int READ_LATENCY = 2
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  sdram_pkg::state_t             state_i,
    input  logic [sdram_pkg::DATA_W-1:0]  dq_i,
    output logic [sdram_pkg::DATA_W-1:0]  rdata_o,
    output logic                          ack_o
);
    import sdram_pkg::*;

    // Read events, one bit per cycle since READ
    logic [READ_LATENCY:0] rd_q;
    logic [DATA_W-1:0]     rdata_q;
    logic                  ack_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            rd_q <= '0;
        else
            rd_q <= {rd_q[READ_LATENCY-1:0], (state_i == ST_READ)};
    end

    // Device presents the word READ_LATENCY edges after it samples READ
    always_ff @(posedge clk_i)
    begin
        if (rd_q[READ_LATENCY])
            rdata_q <= dq_i;
    end

    // Ack a cycle after WRITE0, or with the captured read word
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            ack_q <= 1'b0;
        else
            ack_q <= (state_i == ST_WRITE0) || rd_q[READ_LATENCY];
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

endmodule

//--- rtl/sdram_refresh_timer.sv
// Refresh timer that paces the power-up steps and flags due auto refreshes
`timescale 1ns/1ps

module sdram_refresh_timer #(
    parameter int START_CYCLES   = 200,
    parameter int REFRESH_CYCLES = 500
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   refresh_done_i,
    output logic                   refresh_pending_o,
    output sdram_pkg::init_step_t  init_step_o
);
    import sdram_pkg::*;

    // First expiry covers the start delay plus the init steps
    localparam int INIT_LOAD = START_CYCLES + 100;
    localparam int MAX_LOAD  = (INIT_LOAD > REFRESH_CYCLES) ? INIT_LOAD : REFRESH_CYCLES;
    localparam int CNT_W     = $clog2(MAX_LOAD + 1);

    logic [CNT_W-1:0] count_q;
    logic             pending_q;

    // Down-counter, reload at zero
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            count_q <= CNT_W'(INIT_LOAD);
        else if (count_q == '0)
            count_q <= CNT_W'(REFRESH_CYCLES);
        else
            count_q <= count_q - 1'b1;
    end

    // Pending until the sequencer reaches REFRESH
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pending_q <= 1'b0;
        else if (count_q == '0)
            pending_q <= 1'b1;
        else if (refresh_done_i)
            pending_q <= 1'b0;
    end

    // Init steps, only acted on while the sequencer sits in INIT
    always_comb
    begin
        if (count_q == CNT_W'(50))
            init_step_o = STEP_CKE;
        else if (count_q == CNT_W'(40))
            init_step_o = STEP_PRECHARGE;
        else if (count_q == CNT_W'(30) || count_q == CNT_W'(20))
            init_step_o = STEP_REFRESH;
        else if (count_q == CNT_W'(10))
            init_step_o = STEP_LOAD_MODE;
        else
            init_step_o = STEP_NONE;
    end

    assign refresh_pending_o = pending_q;

    // Sequencer only refreshes when one was asked for
    a_refresh_requested: assert property (@(posedge clk_i) disable iff (rst_i)
        refresh_done_i |-> refresh_pending_o);

endmodule

//--- rtl/sdram_row_tracker.sv
// Open-row table per bank with address split and hit, miss or closed classification
`timescale 1ns/1ps

module sdram_row_tracker #(
    parameter int COL_W = 8,
    parameter int ROW_W = 12
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [31:0]                   addr_i,
    input  sdram_pkg::state_t             state_i,
    input  logic                          close_all_i,
    output sdram_pkg::row_class_t         row_class_o,
    output logic [sdram_pkg::BANK_W-1:0]  bank_o,
    output logic [ROW_W-1:0]              row_o,
    output logic [COL_W-1:0]              col_o
);
    import sdram_pkg::*;

    localparam int BANKS   = 2 ** BANK_W;
    localparam int BANK_LO = COL_W + 2;
    localparam int ROW_LO  = BANK_LO + BANK_W;

    logic [BANKS-1:0] open_q;
    logic [ROW_W-1:0] active_row_q [BANKS];

    // --------------------
    // Address split
    // --------------------
    // Byte lane bits dropped, word column first
    assign col_o  = addr_i[COL_W+1:2];
    assign bank_o = addr_i[BANK_LO +: BANK_W];
    assign row_o  = addr_i[ROW_LO +: ROW_W];

    // Open flags follow ACTIVATE and PRECHARGE
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            open_q <= '0;
        else if (state_i == ST_ACTIVATE)
            open_q[bank_o] <= 1'b1;
        else if (state_i == ST_PRECHARGE)
        begin
            if (close_all_i)
                open_q <= '0;
            else
                open_q[bank_o] <= 1'b0;
        end
    end

    // Row held by each bank
    always_ff @(posedge clk_i)
    begin
        if (state_i == ST_ACTIVATE)
            active_row_q[bank_o] <= row_o;
    end

    // Classify the pending request
    always_comb
    begin
        if (!open_q[bank_o])
            row_class_o = ROW_CLOSED;
        else if (active_row_q[bank_o] == row_o)
            row_class_o = ROW_HIT;
        else
            row_class_o = ROW_MISS;
    end

endmodule

//--- rtl/sdram_sequencer.sv
// Main SDRAM FSM with timing delays, request accept and same-row chaining
`timescale 1ns/1ps

module sdram_sequencer #(
    parameter int TRCD_CYCLES  = 1,
    parameter int TRP_CYCLES   = 1,
    parameter int TRFC_CYCLES  = 3,
    parameter int READ_LATENCY = 2
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         rd_i,
    input  logic [sdram_pkg::DQM_W-1:0]  wr_i,
    input  logic                         refresh_pending_i,
    input  sdram_pkg::row_class_t        row_class_i,
    output sdram_pkg::state_t            state_o,
    output logic                         close_all_o,
    output logic                         refresh_done_o,
    output logic                         accept_o
);
    import sdram_pkg::*;

    state_t state_q, next_state;
    state_t target_q, target_next;
    state_t delay_state_q;
    logic [DELAY_W-1:0] delay_q, delay_next;
    logic is_wr, req, hit, chain_rd, chain_wr;

    // Read wins when both are raised
    assign is_wr = (wr_i != '0) && !rd_i;
    assign req   = rd_i || (wr_i != '0);
    assign hit   = (row_class_i == ROW_HIT);

    // Same-row follow-on, a pending refresh breaks the chain
    assign chain_rd = !refresh_pending_i && rd_i && hit;
    assign chain_wr = !refresh_pending_i && is_wr && hit;

    // --------------------
    // Next state
    // --------------------
    always_comb
    begin
        next_state  = state_q;
        target_next = target_q;
        case (state_q)
            // Leave INIT once the first refresh falls due
            ST_INIT:
                if (refresh_pending_i)
                    next_state = ST_IDLE;
            ST_IDLE:
            begin
                // Close every bank ahead of refresh
                if (refresh_pending_i)
                begin
                    next_state  = ST_PRECHARGE;
                    target_next = ST_REFRESH;
                end
                else if (req)
                begin
                    target_next = is_wr ? ST_WRITE0 : ST_READ;
                    if (hit)
                        next_state = target_next;
                    else if (row_class_i == ROW_MISS)
                        next_state = ST_PRECHARGE;
                    else
                        next_state = ST_ACTIVATE;
                end
            end
            ST_ACTIVATE:  next_state = target_q;
            ST_READ:      next_state = ST_READ_WAIT;
            ST_READ_WAIT: next_state = chain_rd ? ST_READ : ST_IDLE;
            ST_WRITE0:    next_state = ST_WRITE1;
            ST_WRITE1:    next_state = chain_wr ? ST_WRITE0 : ST_IDLE;
            // Refresh close or row swap
            ST_PRECHARGE: next_state = (target_q == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
            ST_REFRESH:   next_state = ST_IDLE;
            ST_DELAY:     next_state = delay_state_q;
            default:      next_state = ST_IDLE;
        endcase
    end

    // --------------------
    // Delay load
    // --------------------
    always_comb
    begin
        case (state_q)
            ST_ACTIVATE:  delay_next = DELAY_W'(TRCD_CYCLES);
            // Chained read skips the CAS wait
            ST_READ_WAIT: delay_next = chain_rd ? '0 : DELAY_W'(READ_LATENCY);
            ST_PRECHARGE: delay_next = DELAY_W'(TRP_CYCLES);
            ST_REFRESH:   delay_next = DELAY_W'(TRFC_CYCLES);
            ST_DELAY:     delay_next = delay_q - 1'b1;
            default:      delay_next = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q       <= ST_INIT;
            target_q      <= ST_IDLE;
            delay_state_q <= ST_IDLE;
            delay_q       <= '0;
        end
        else
        begin
            target_q <= target_next;
            delay_q  <= delay_next;
            // Park in DELAY, remember where to go after
            if (delay_next != '0)
                state_q <= ST_DELAY;
            else
                state_q <= next_state;
            if (state_q != ST_DELAY && delay_next != '0)
                delay_state_q <= next_state;
        end
    end

    assign state_o        = state_q;
    assign close_all_o    = (target_q == ST_REFRESH);
    assign refresh_done_o = (state_q == ST_REFRESH);
    assign accept_o       = (state_q == ST_READ) || (state_q == ST_WRITE0);

    // Accept only with a live request on an open row
    a_accept_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        accept_o |-> req && hit);

endmodule

//--- testbench/sdram_device_model.sv
// Behavioral SDR SDRAM device with bank row state, masked writes and CAS latency read return
`timescale 1ns/1ps

module sdram_device_model #(
    parameter int COL_W        = 8,
    parameter int READ_LATENCY = 2
) (
    input  logic        clk_i,
    input  logic        cke_i,
    input  logic        cs_i,
    input  logic        ras_i,
    input  logic        cas_i,
    input  logic        we_i,
    input  logic [1:0]  ba_i,
    input  logic [12:0] addr_i,
    input  logic [3:0]  dqm_i,
    input  logic [31:0] dq_i,
    output logic [31:0] dq_o,
    output int          row_err_o,
    output int          ref_err_o
);
    import sdram_pkg::*;

    logic [31:0] mem [int];
    logic [3:0]  open_q = '0;
    logic [12:0] row_q [4];
    logic [31:0] pipe_q [READ_LATENCY];
    logic [3:0]  cmd;

    assign cmd  = {cs_i, ras_i, cas_i, we_i};
    // Last pipe stage is on the bus for the capture edge
    assign dq_o = pipe_q[READ_LATENCY-1];

    initial
    begin
        row_err_o = 0;
        ref_err_o = 0;
    end

    always @(posedge clk_i)
    begin
        int          key;
        logic [31:0] word;
        for (int i = READ_LATENCY - 1; i > 0; i--)
            pipe_q[i] <= pipe_q[i-1];
        key = {row_q[ba_i], ba_i, addr_i[COL_W-1:0]};
        if (cke_i)
        begin
            case (cmd)
                CMD_ACTIVE:
                begin
                    if (open_q[ba_i])
                    begin
                        $display("Model: ACTIVATE to bank %0d which is already open", ba_i);
                        row_err_o++;
                    end
                    open_q[ba_i] = 1'b1;
                    row_q[ba_i]  = addr_i;
                end
                CMD_PRECHARGE:
                    if (addr_i[ALL_BANKS_BIT])
                        open_q = '0;
                    else
                        open_q[ba_i] = 1'b0;
                CMD_REFRESH:
                    if (open_q != '0)
                    begin
                        $display("Model: REFRESH issued while banks %b are open", open_q);
                        ref_err_o++;
                    end
                CMD_READ, CMD_WRITE:
                begin
                    if (!open_q[ba_i])
                    begin
                        $display("Model: column access to closed bank %0d", ba_i);
                        row_err_o++;
                    end
                    word = mem.exists(key) ? mem[key] : 32'h0;
                    if (cmd == CMD_WRITE)
                    begin
                        // Mask bit high keeps the stored byte
                        for (int b = 0; b < 4; b++)
                            if (!dqm_i[b])
                                word[8*b +: 8] = dq_i[8*b +: 8];
                        mem[key] = word;
                    end
                    else
                        pipe_q[0] <= word;
                end
                default:
                    ;
            endcase
        end
    end

endmodule

//--- testbench/tb_sdram_ctrl.sv
// Testbench for the SDRAM controller with random requests, scoreboard and timing checks
`timescale 1ns/1ps

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int START_CYCLES   = 200;
    localparam int REFRESH_CYCLES = 500;
    localparam int READ_LATENCY   = 2;
    localparam int NUM_REQ        = 200;
    localparam int REF_LIMIT      = REFRESH_CYCLES + 1 + 40;
    localparam int INIT_CYCLES    = START_CYCLES + 150;
    localparam int WATCHDOG_NS    = (NUM_REQ * 40 + INIT_CYCLES) * 4;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        rd_i;
    logic [3:0]  wr_i;
    logic [31:0] addr_i, wdata_i, rdata_o, dq_o, dq_i;
    logic        accept_o, ack_o, cke_o, cs_o, ras_o, cas_o, we_o, dq_oe_o;
    logic [1:0]  ba_o;
    logic [12:0] addr_o;
    logic [3:0]  dqm_o, cmd;
    int          row_err, ref_err;

    // --------------------
    // Checker state
    // --------------------
    logic [31:0] sb [int];
    int          due_q[$];
    bit          isrd_q[$];
    logic [31:0] exp_q[$];
    int cyc = 0, init_idx = 0, last_ref = 0, ref_cnt = 0;
    int init_err = 0, data_err = 0, ack_err = 0, seq_err = 0, pin_err = 0;
    int req_cnt = 0, acc_cnt = 0, ack_cnt = 0;
    logic [31:0] seed = 32'h516e_a11f;

    always #2 clk_i = ~clk_i;

    sdram_ctrl_top #(.START_CYCLES(START_CYCLES), .REFRESH_CYCLES(REFRESH_CYCLES),
        .READ_LATENCY(READ_LATENCY)) dut_i (
        .clk_i, .rst_i, .rd_i, .wr_i, .addr_i, .wdata_i, .accept_o, .ack_o, .rdata_o,
        .cke_o, .cs_o, .ras_o, .cas_o, .we_o, .ba_o, .addr_o, .dqm_o, .dq_o, .dq_oe_o, .dq_i);

    sdram_device_model #(.READ_LATENCY(READ_LATENCY)) u_model (
        .clk_i, .cke_i(cke_o), .cs_i(cs_o), .ras_i(ras_o), .cas_i(cas_o), .we_i(we_o),
        .ba_i(ba_o), .addr_i(addr_o), .dqm_i(dqm_o), .dq_i(dq_o), .dq_o(dq_i),
        .row_err_o(row_err), .ref_err_o(ref_err));

    assign cmd = {cs_o, ras_o, cas_o, we_o};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic print_result(input string name, input int errs);
        $display("%-14s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    always @(posedge clk_i)
        cyc++;

    // Pin monitor, init order and refresh spacing
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (init_idx == 0 && cke_o)
                init_idx = 1;
            if (cmd != CMD_NOP && init_idx < 5)
            begin
                if (init_idx == 1 && cmd == CMD_PRECHARGE && addr_o[ALL_BANKS_BIT])
                    init_idx = 2;
                else if ((init_idx == 2 || init_idx == 3) && cmd == CMD_REFRESH)
                    init_idx++;
                else if (init_idx == 4 && cmd == CMD_LOAD_MODE && addr_o == MODE_REG)
                    init_idx = 5;
                else
                begin
                    $display("** Error: init cmd = %h, addr_o = %h at step %0d",
                             cmd, addr_o, init_idx);
                    init_err++;
                end
            end
            // Data bus driven only alongside a WRITE command
            if (dq_oe_o !== (cmd == CMD_WRITE))
            begin
                $display("** Error: dq_oe_o = %h, expected %h", dq_oe_o, cmd == CMD_WRITE);
                pin_err++;
            end
            if (accept_o && init_idx < 5)
            begin
                $display("Request accepted before the power-up sequence finished");
                init_err++;
            end
            if (cmd == CMD_REFRESH && init_idx >= 5)
            begin
                if (cyc - last_ref > REF_LIMIT)
                begin
                    $display("Refresh gap of %0d cycles exceeds %0d", cyc - last_ref, REF_LIMIT);
                    seq_err++;
                end
                last_ref = cyc;
                ref_cnt++;
            end
            if (accept_o)
                acc_cnt++;
        end
    end

    // Ack monitor against the expected queue
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (ack_o)
            begin
                ack_cnt++;
                if (due_q.size() == 0)
                begin
                    $display("Ack seen with no request outstanding");
                    ack_err++;
                end
                else
                begin
                    if (due_q[0] != cyc)
                    begin
                        $display("** Error: ack_o cycle = %h, expected %h", cyc, due_q[0]);
                        ack_err++;
                    end
                    if (isrd_q[0] && rdata_o !== exp_q[0])
                    begin
                        $display("** Error: rdata_o = %h, expected %h", rdata_o, exp_q[0]);
                        data_err++;
                    end
                    void'(due_q.pop_front());
                    void'(isrd_q.pop_front());
                    void'(exp_q.pop_front());
                end
            end
            else if (due_q.size() > 0 && due_q[0] < cyc)
            begin
                $display("Ack missing for a request due in cycle %0d", due_q[0]);
                ack_err++;
                void'(due_q.pop_front());
                void'(isrd_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        int          widx, total;
        logic [31:0] word;
        rst_i   = 1'b1;
        rd_i    = 1'b0;
        wr_i    = '0;
        addr_i  = '0;
        wdata_i = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        for (int n = 0; n < NUM_REQ; n++)
        begin
            seed = xorshift(seed);
            // Small pool: four rows, four banks, sixteen columns
            addr_i = {8'h00, 10'd0, seed[9:8], seed[11:10], 4'd0, seed[15:12], 2'b00};
            rd_i   = seed[0];
            wr_i   = seed[0] ? 4'h0 : ((seed[7:4] == 4'h0) ? 4'hf : seed[7:4]);
            seed    = xorshift(seed);
            wdata_i = seed;
            req_cnt++;
            @(negedge clk_i);
            while (!accept_o)
                @(negedge clk_i);
            widx = addr_i[23:2];
            word = sb.exists(widx) ? sb[widx] : 32'h0;
            if (rd_i)
            begin
                due_q.push_back(cyc + READ_LATENCY + 2);
                isrd_q.push_back(1'b1);
                exp_q.push_back(word);
            end
            else
            begin
                for (int b = 0; b < 4; b++)
                    if (wr_i[b])
                        word[8*b +: 8] = wdata_i[8*b +: 8];
                sb[widx] = word;
                due_q.push_back(cyc + 1);
                isrd_q.push_back(1'b0);
                exp_q.push_back(32'h0);
            end
            // Hold through the accept edge, change on the next falling edge
            @(negedge clk_i);
        end
        rd_i = 1'b0;
        wr_i = '0;
        while (due_q.size() > 0)
            @(negedge clk_i);
        repeat (5) @(negedge clk_i);
        if (cyc - last_ref > REF_LIMIT || ref_cnt == 0)
        begin
            $display("No refresh within %0d cycles of the end", REF_LIMIT);
            seq_err++;
        end
        if (init_idx != 5)
        begin
            $display("Power-up sequence did not complete");
            init_err++;
        end
        if (acc_cnt != req_cnt || ack_cnt != req_cnt)
        begin
            $display("Request count %0d differs from accepts or acks", req_cnt);
            seq_err++;
        end
        print_result("init order", init_err);
        print_result("read data", data_err);
        print_result("ack timing", ack_err);
        print_result("row policy", row_err);
        print_result("refresh", seq_err + ref_err);
        print_result("write bus", pin_err);
        total = init_err + data_err + ack_err + row_err + ref_err + seq_err + pin_err;
        $display("Requests %0d, accepts %0d, acks %0d, refreshes %0d, errors %0d",
                 req_cnt, acc_cnt, ack_cnt, ref_cnt, total);
        if (total == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Watchdog sized from request count and init time
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d requests issued", WATCHDOG_NS, req_cnt);
        $display("Verification failed");
        $finish;
    end

endmodule
